/* sim.f */
design/mem_pkg.sv
design/access_ctrl.sv
design/byte_lane_plan.sv
design/avm_burst_master.sv
design/read_merge.sv
design/mem_access_top.sv
dv/mem_access_properties.sv
dv/tb_mem_access.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_access -Mdir obj_dir -o sim_mem_access -f sim.f \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_mem_access 2>&1)"
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }

/* dv/tb_mem_access.sv */
`default_nettype none

module tb_mem_access
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS      = 10;
    localparam int RST_CYCLES  = 10;
    localparam int N_ALIGNED   = 8;
    localparam int N_UNALIGNED = 12;
    localparam int N_RANDOM    = 150;
    localparam int N_BP        = 40;
    localparam int N_OPS = 2*N_ALIGNED + 4*N_UNALIGNED + 2*(N_RANDOM + N_BP); // upper bound

    logic               clk = 1'b0;
    logic               rst_n;
    rd_req_t            rd_req;
    logic               rd_req_valid;
    logic               rd_req_ready;
    wr_req_t            wr_req;
    logic               wr_req_valid;
    logic               wr_req_ready;
    dword_t             rd_data;
    logic               rd_resp_valid;
    logic               rd_resp_ready;
    logic               wr_done;
    dword_addr_t        avm_address;
    dword_t             avm_writedata;
    byte_en_t           avm_byteenable;
    logic [BURST_W-1:0] avm_burstcount;
    logic               avm_read;
    logic               avm_write;
    logic               avm_waitrequest;
    logic               avm_readdatavalid;
    dword_t             avm_readdata;

    integer     seed = 8;
    logic [7:0] bus_mem [0:255];                 // 256-byte window behind the bus
    logic [7:0] ref_mem [0:255];                 // reference bytes
    dword_t     exp_q [$];                       // expected read results, in order
    byte_en_t   rd_be_exp;                       // lanes of the read in flight
    int         wr_pending;                      // writes still owed a wr_done
    int         err_cnt;
    int         chk_cnt;
    int         fail_tests;
    logic       bp_mode;                         // random rd_resp_ready stalls
    logic       resp_held;
    dword_t     held_data;

    always #(CLK_NS/2) clk = ~clk;

    mem_access_top DUT (.*);

    // --------------------
    // checks and model
    task automatic compare_data(input string name, input dword_t got, input dword_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_enables(input string name, input byte_en_t got,
                                   input byte_en_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic dword_t model_read(input addr_t addr, input len_t len);
        dword_t d;
        d = '0;                                  // upper bytes stay zero
        for (int k = 0; k < int'(len); k++) begin
            d[8*k +: 8] = ref_mem[8'(addr + addr_t'(k))];
        end
        return d;
    endfunction

    task automatic model_write(input addr_t addr, input len_t len, input dword_t data);
        for (int k = 0; k < int'(len); k++) begin
            ref_mem[8'(addr + addr_t'(k))] = data[8*k +: 8];
        end
    endtask

    function automatic byte_en_t read_enables(input addr_t addr, input len_t len);
        byte_en_t be;
        be = '0;
        for (int k = 0; k < int'(len); k++) begin
            be[2'(int'(addr[1:0]) + k)] = 1'b1;  // lanes of both beats in one mask
        end
        return be;
    endfunction

    // --------------------
    // avalon memory with waitrequest and response stalls
    initial begin
        int         rd_left;
        int         rd_wait;
        int         wr_beat;
        logic [5:0] rd_ptr;
        logic [5:0] wr_ptr;
        rd_left = 0;
        rd_wait = 0;
        wr_beat = 0;
        rd_ptr  = '0;
        avm_waitrequest   = 1'b0;
        avm_readdatavalid = 1'b0;
        avm_readdata      = '0;
        rd_resp_ready     = 1'b1;
        forever begin
            @(negedge clk);
            avm_readdatavalid = 1'b0;
            rd_resp_ready = bp_mode ? (($unsigned($random(seed)) % 3) == 0) : 1'b1;
            if (!rst_n) begin
                rd_left = 0;
                wr_beat = 0;
            end else if (rd_left > 0) begin
                if (rd_wait > 1) begin
                    rd_wait--;                   // still in read latency
                end else begin
                    avm_readdatavalid = 1'b1;
                    avm_readdata = {bus_mem[{rd_ptr, 2'd3}], bus_mem[{rd_ptr, 2'd2}],
                                    bus_mem[{rd_ptr, 2'd1}], bus_mem[{rd_ptr, 2'd0}]};
                    rd_ptr++;
                    rd_left--;
                    rd_wait = 1 + int'($unsigned($random(seed)) % 3);
                end
            end
            avm_waitrequest = ($unsigned($random(seed)) % 4) == 0;
            #1;                                  // settle, then see what the edge takes
            if (rst_n && avm_read && !avm_waitrequest) begin
                compare_enables("avm_byteenable", avm_byteenable, rd_be_exp);
                rd_ptr  = avm_address[7:2];
                rd_left = int'(avm_burstcount);
                rd_wait = 1 + int'($unsigned($random(seed)) % 3); // 1 to 3 cycles
            end
            if (rst_n && avm_write && !avm_waitrequest) begin
                wr_ptr = avm_address[7:2] + 6'(wr_beat); // address held at beat 0
                for (int b = 0; b < 4; b++) begin
                    if (avm_byteenable[b]) bus_mem[{wr_ptr, 2'(b)}] = avm_writedata[8*b +: 8];
                end
                wr_beat++;
                if (wr_beat == int'(avm_burstcount)) wr_beat = 0;
            end
        end
    end

    // --------------------
    // monitor
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (rst_n) begin
                if (wr_req_valid && wr_req_ready) begin
                    model_write(wr_req.addr, wr_req.len, wr_req.data);
                    wr_pending++;
                end
                if (rd_req_valid && rd_req_ready) begin
                    exp_q.push_back(model_read(rd_req.addr, rd_req.len));
                    rd_be_exp = read_enables(rd_req.addr, rd_req.len);
                end
                if (wr_done) begin
                    if (wr_pending == 0) begin
                        err_cnt++;
                        $display("wr_done pulse at %0d ns with no write outstanding", $time);
                    end else begin
                        wr_pending--;
                    end
                end
                if (resp_held) begin             // response must not move
                    compare_flag("rd_resp_valid", rd_resp_valid, 1'b1);
                    compare_data("rd_data", rd_data, held_data);
                end
                if (rd_resp_valid) begin
                    compare_flag("rd_req_ready", rd_req_ready, 1'b0);
                    compare_flag("wr_req_ready", wr_req_ready, 1'b0);
                    if (rd_resp_ready && exp_q.size() == 0) begin
                        err_cnt++;
                        $display("read response at %0d ns with no read outstanding", $time);
                    end else if (rd_resp_ready) begin
                        compare_data("rd_data", rd_data, exp_q.pop_front());
                    end
                end
                resp_held = rd_resp_valid && !rd_resp_ready;
                held_data = rd_data;
            end
        end
    end

    // --------------------
    // stimulus
    task automatic issue(input logic wr_en, input logic rd_en);
        logic wr_hit;
        logic rd_hit;
        wr_req_valid = wr_en;
        rd_req_valid = rd_en;
        while (wr_req_valid || rd_req_valid) begin
            #1;
            wr_hit = wr_req_valid && wr_req_ready;
            rd_hit = rd_req_valid && rd_req_ready;
            @(negedge clk);
            if (wr_hit) wr_req_valid = 1'b0;     // the loser stays valid
            if (rd_hit) rd_req_valid = 1'b0;
        end
    endtask

    task automatic write_bytes(input addr_t addr, input len_t len, input dword_t data);
        wr_req.addr = addr;
        wr_req.len  = len;
        wr_req.data = data;
        issue(1'b1, 1'b0);
    endtask

    task automatic read_bytes(input addr_t addr, input len_t len);
        rd_req.addr = addr;
        rd_req.len  = len;
        issue(1'b0, 1'b1);
    endtask

    task automatic random_traffic(input int n);
        logic wr_en;
        logic rd_en;
        for (int i = 0; i < n; i++) begin
            wr_en = ($unsigned($random(seed)) % 4) != 0;
            rd_en = (($unsigned($random(seed)) % 4) != 0) || !wr_en; // both valid often
            wr_req.addr = addr_t'($random(seed));
            wr_req.len  = len_t'(1 + $unsigned($random(seed)) % 4);
            wr_req.data = dword_t'($random(seed));
            rd_req.addr = addr_t'($random(seed));
            rd_req.len  = len_t'(1 + $unsigned($random(seed)) % 4);
            issue(wr_en, rd_en);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        while (exp_q.size() != 0 || wr_pending != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // --------------------
    initial begin
        int    e;
        int    off;
        len_t  len;
        addr_t a;
        rst_n        = 1'b0;
        rd_req       = '0;
        rd_req_valid = 1'b0;
        wr_req       = '0;
        wr_req_valid = 1'b0;
        bp_mode      = 1'b0;
        resp_held    = 1'b0;
        wr_pending   = 0;
        err_cnt      = 0;
        chk_cnt      = 0;
        fail_tests   = 0;
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = 8'(i * 37) ^ 8'h5a;     // distinct per byte address
            ref_mem[i] = bus_mem[i];
        end

        e = err_cnt;                             // outputs quiet in reset
        repeat (RST_CYCLES) begin
            @(negedge clk);
            compare_flag("avm_read", avm_read, 1'b0);
            compare_flag("avm_write", avm_write, 1'b0);
            compare_flag("rd_resp_valid", rd_resp_valid, 1'b0);
            compare_flag("wr_done", wr_done, 1'b0);
        end
        rst_n = 1'b1;
        end_test("reset_values", e);

        e = err_cnt;
        for (int i = 0; i < N_ALIGNED; i++) begin
            write_bytes(addr_t'(32'h1000_0000 + 32*i + 4*(i % 4)), 3'd4, dword_t'($random(seed)));
        end
        for (int i = 0; i < N_ALIGNED; i++) begin
            read_bytes(addr_t'(32'h1000_0000 + 32*i + 4*(i % 4)), 3'd4);
        end
        end_test("aligned_dwords", e);

        e = err_cnt;                             // offset + len always above 4
        for (int i = 0; i < N_UNALIGNED; i++) begin
            off = 1 + int'($unsigned($random(seed)) % 3);
            len = len_t'(5 - off + int'($unsigned($random(seed)) % off));
            a   = (addr_t'($random(seed)) & ~addr_t'(3)) | addr_t'(off);
            write_bytes(a, len, dword_t'($random(seed)));
            read_bytes(a, len);
            read_bytes(a & ~addr_t'(3), 3'd4);   // neighbours in both dwords
            read_bytes((a & ~addr_t'(3)) + addr_t'(4), 3'd4);
        end
        end_test("two_beat_bursts", e);

        e = err_cnt;
        random_traffic(N_RANDOM);
        end_test("random_mixed", e);

        e = err_cnt;
        bp_mode = 1'b1;
        random_traffic(N_BP);
        end_test("response_backpressure", e);
        bp_mode = 1'b0;

        err_cnt += int'(DUT.u_props.violations);
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 5, fail_tests, chk_cnt, err_cnt);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog allows 40 cycles per operation
    initial begin
        #((RST_CYCLES + N_OPS * 40) * CLK_NS);
        $display("watchdog expired at %0d ns, traffic did not drain", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/mem_access_properties.sv */
`default_nettype none

module mem_access_properties
    import mem_pkg::*;
(
    input wire                clk,
    input wire                rst_n,
    input wire rd_req_t       rd_req,
    input wire                rd_req_valid,
    input wire wr_req_t       wr_req,
    input wire                wr_req_valid,
    input wire dword_addr_t   avm_address,
    input wire dword_t        avm_writedata,
    input wire byte_en_t      avm_byteenable,
    input wire [BURST_W-1:0]  avm_burstcount,
    input wire                avm_read,
    input wire                avm_write,
    input wire                avm_waitrequest
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned violations = 0;                 // failed rules so far

    // --------------------
    // bus port
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(avm_read && avm_write))
        else begin
            violations++;
            $error("avm_read and avm_write asserted together");
        end

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_read) && $stable(avm_write) && $stable(avm_address)
            && $stable(avm_burstcount) && $stable(avm_byteenable)
            && $stable(avm_writedata))
        else begin
            violations++;
            $error("bus command changed under waitrequest");
        end

    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        (avm_read || avm_write) |->
            (avm_burstcount == BURST_W'(1) || avm_burstcount == BURST_W'(2)))
        else begin
            violations++;
            $error("avm_burstcount outside 1..2");
        end

    // --------------------
    // request lengths
    a_rd_len: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid |-> (rd_req.len >= len_t'(1) && rd_req.len <= len_t'(MAX_LEN)))
        else begin
            violations++;
            $error("read request length outside 1..4");
        end

    a_wr_len: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req_valid |-> (wr_req.len >= len_t'(1) && wr_req.len <= len_t'(MAX_LEN)))
        else begin
            violations++;
            $error("write request length outside 1..4");
        end

endmodule

bind mem_access_top mem_access_properties u_props (.*);

`default_nettype wire

/* design/mem_access_top.sv */
`default_nettype none

module mem_access_top
    import mem_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire rd_req_t         rd_req,
    input  wire                  rd_req_valid,
    output logic                 rd_req_ready,
    input  wire wr_req_t         wr_req,
    input  wire                  wr_req_valid,
    output logic                 wr_req_ready,

    output dword_t               rd_data,
    output logic                 rd_resp_valid,
    input  wire                  rd_resp_ready,
    output logic                 wr_done,

    // avalon master
    output dword_addr_t          avm_address,
    output dword_t               avm_writedata,
    output byte_en_t             avm_byteenable,
    output logic [BURST_W-1:0]   avm_burstcount,
    output logic                 avm_read,
    output logic                 avm_write,
    input  wire                  avm_waitrequest,
    input  wire                  avm_readdatavalid,
    input  wire dword_t          avm_readdata
);

    // --------------------
    access_t    access;
    logic       acc_valid;
    logic       acc_ready;
    burst_cmd_t cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       cmd_accept;                      // read command taken
    logic       bus_done;
    logic       beat_valid;
    dword_t     beat_data;

    assign cmd_accept = cmd_valid & cmd_ready & (cmd.op == OP_READ);

    access_ctrl u_ctrl (
        .clk, .rst_n,
        .rd_req, .rd_req_valid, .rd_req_ready,
        .wr_req, .wr_req_valid, .wr_req_ready,
        .rd_resp_valid, .rd_resp_ready,
        .access, .acc_valid, .acc_ready,
        .bus_done, .wr_done
    );

    byte_lane_plan u_plan (
        .access, .acc_valid, .acc_ready,
        .cmd, .cmd_valid, .cmd_ready
    );

    avm_burst_master u_bus (
        .clk, .rst_n,
        .cmd, .cmd_valid, .cmd_ready,
        .avm_address, .avm_writedata, .avm_byteenable, .avm_burstcount,
        .avm_read, .avm_write,
        .avm_waitrequest, .avm_readdatavalid, .avm_readdata,
        .beat_valid, .beat_data, .bus_done
    );

    read_merge u_merge (
        .clk, .rst_n,
        .cmd, .cmd_accept,
        .beat_valid, .beat_data,
        .rd_data, .rd_resp_valid, .rd_resp_ready
    );

endmodule

`default_nettype wire

/* design/read_merge.sv */
`default_nettype none

module read_merge
    import mem_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire burst_cmd_t      cmd,
    input  wire                  cmd_accept,     // read commands only

    input  wire                  beat_valid,
    input  wire dword_t          beat_data,

    output dword_t               rd_data,
    output logic                 rd_resp_valid,
    input  wire                  rd_resp_ready
);

    logic [1:0]                  offset_q;
    len_t                        len_q;
    logic                        two_q;          // expects two beats
    logic                        idx;            // next beat slot
    logic [2*8*DWORD_BYTES-1:0]  beats_q;
    logic [2*8*DWORD_BYTES-1:0]  shifted;

    // --------------------
    // right-align and mask
    assign shifted = beats_q >> {offset_q, 3'b000};

    always_comb begin
        for (int i = 0; i < DWORD_BYTES; i++) begin
            rd_data[8*i +: 8] = (i < int'(len_q)) ? shifted[8*i +: 8] : 8'h00;
        end
    end

    // --------------------
    // response control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_resp_valid <= 1'b0;
            idx           <= 1'b0;
        end else begin
            if (cmd_accept) idx <= 1'b0;
            else if (beat_valid) idx <= 1'b1;
            if (beat_valid && (idx == two_q)) rd_resp_valid <= 1'b1; // last beat in
            else if (rd_resp_valid && rd_resp_ready) rd_resp_valid <= 1'b0;
        end
    end

    // beat storage and access shape
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            offset_q <= cmd.offset;
            len_q    <= cmd.len;
            two_q    <= cmd.two_beats;
        end
        if (beat_valid) begin
            if (idx) beats_q[63:32] <= beat_data;
            else beats_q[31:0] <= beat_data;
        end
    end

endmodule

`default_nettype wire

/* design/avm_burst_master.sv */
`default_nettype none

module avm_burst_master
    import mem_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire burst_cmd_t      cmd,
    input  wire                  cmd_valid,
    output logic                 cmd_ready,

    output dword_addr_t          avm_address,
    output dword_t               avm_writedata,
    output byte_en_t             avm_byteenable,
    output logic [BURST_W-1:0]   avm_burstcount,
    output logic                 avm_read,
    output logic                 avm_write,
    input  wire                  avm_waitrequest,
    input  wire                  avm_readdatavalid,
    input  wire dword_t          avm_readdata,

    output logic                 beat_valid,
    output dword_t               beat_data,
    output logic                 bus_done
);

    bus_state_t state;
    burst_cmd_t cmd_q;                           // held for the whole burst
    logic       beat;                            // current beat index
    logic       last_beat;

    assign last_beat = (beat == cmd_q.two_beats);
    assign cmd_ready = (state == BS_IDLE);

    // --------------------
    // bus drive
    assign avm_read       = (state == BS_READ_REQ);
    assign avm_write      = (state == BS_WRITE);
    assign avm_address    = cmd_q.dword_addr;    // first beat address
    assign avm_burstcount = cmd_q.two_beats ? BURST_W'(2) : BURST_W'(1);
    assign avm_writedata  = beat ? cmd_q.wdata[63:32] : cmd_q.wdata[31:0];

    always_comb begin
        if (cmd_q.op == OP_READ) avm_byteenable = cmd_q.be0 | cmd_q.be1; // one mask
        else if (beat) avm_byteenable = cmd_q.be1;
        else avm_byteenable = cmd_q.be0;
    end

    assign beat_valid = (state == BS_READ_DATA) && avm_readdatavalid;
    assign beat_data  = avm_readdata;

    // --------------------
    // fsm and beat count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= BS_IDLE;
            beat     <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= 1'b0;                    // pulse
            unique case (state)
                BS_IDLE: begin
                    beat <= 1'b0;
                    if (cmd_valid) begin
                        if (cmd.op == OP_WRITE) state <= BS_WRITE;
                        else state <= BS_READ_REQ;
                    end
                end
                BS_WRITE: begin
                    if (!avm_waitrequest) begin  // beat accepted
                        if (last_beat) begin
                            state    <= BS_IDLE;
                            bus_done <= 1'b1;
                        end else begin
                            beat <= 1'b1;
                        end
                    end
                end
                BS_READ_REQ: begin
                    if (!avm_waitrequest) state <= BS_READ_DATA; // command taken
                end
                BS_READ_DATA: begin
                    if (avm_readdatavalid) begin
                        if (last_beat) begin
                            state    <= BS_IDLE;
                            bus_done <= 1'b1;
                        end else begin
                            beat <= 1'b1;
                        end
                    end
                end
                default: state <= BS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) cmd_q <= cmd;
    end

endmodule

`default_nettype wire

/* design/byte_lane_plan.sv */
`default_nettype none

module byte_lane_plan
    import mem_pkg::*;
(
    input  wire access_t     access,
    input  wire              acc_valid,
    output logic             acc_ready,

    output burst_cmd_t       cmd,
    output logic             cmd_valid,
    input  wire              cmd_ready
);

    logic [1:0]                 offset;        // low address bits
    logic [3:0]                 span;          // offset + len, up to 7
    logic [2*DWORD_BYTES-1:0]   len_mask;      // len ones from bit 0
    logic [2*DWORD_BYTES-1:0]   lane_mask;     // enables over both beats

    assign cmd_valid = acc_valid;              // handshake passes through
    assign acc_ready = cmd_ready;

    assign offset    = access.addr[1:0];
    assign span      = {2'b00, offset} + {1'b0, access.len};
    assign len_mask  = ~({(2*DWORD_BYTES){1'b1}} << access.len);
    assign lane_mask = len_mask << offset;

    // --------------------
    // burst command
    always_comb begin
        cmd.op         = access.op;
        cmd.dword_addr = access.addr[ADDR_W-1:2];
        cmd.two_beats  = (span > 4'(DWORD_BYTES)); // spills into next dword
        cmd.be0        = lane_mask[DWORD_BYTES-1:0];
        cmd.be1        = lane_mask[2*DWORD_BYTES-1:DWORD_BYTES]; // overflow bytes
        cmd.wdata      = {{(8*DWORD_BYTES){1'b0}}, access.wdata} << {offset, 3'b000};
        cmd.offset     = offset;
        cmd.len        = access.len;
    end

endmodule

`default_nettype wire

/* design/access_ctrl.sv */
`default_nettype none

module access_ctrl
    import mem_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire rd_req_t     rd_req,
    input  wire              rd_req_valid,
    output logic             rd_req_ready,

    input  wire wr_req_t     wr_req,
    input  wire              wr_req_valid,
    output logic             wr_req_ready,

    input  wire              rd_resp_valid,      // seen at top level
    input  wire              rd_resp_ready,

    output access_t          access,
    output logic             acc_valid,
    input  wire              acc_ready,

    input  wire              bus_done,
    output logic             wr_done
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        last_wr;                        // write served last time
    logic        wr_take;
    logic        rd_take;

    // --------------------
    // arbitration in idle only
    assign wr_req_ready = (state == CS_IDLE) && (!rd_req_valid || !last_wr);
    assign rd_req_ready = (state == CS_IDLE) && (!wr_req_valid || last_wr);
    assign wr_take      = wr_req_valid && wr_req_ready;
    assign rd_take      = rd_req_valid && rd_req_ready; // never with wr_take

    assign acc_valid    = (state == CS_ISSUE);
    assign wr_done      = (state == CS_WAIT_WR) && bus_done; // one cycle

    // --------------------
    // fsm
    always_comb begin
        state_nxt = state;
        unique case (state)
            CS_IDLE: begin
                if (wr_take || rd_take) state_nxt = CS_ISSUE;
            end
            CS_ISSUE: begin
                if (acc_ready) begin                 // burst master took it
                    if (access.op == OP_WRITE) state_nxt = CS_WAIT_WR;
                    else state_nxt = CS_WAIT_RD;
                end
            end
            CS_WAIT_WR: begin
                if (bus_done) state_nxt = CS_IDLE;   // last beat accepted
            end
            CS_WAIT_RD: begin
                if (rd_resp_valid && rd_resp_ready) state_nxt = CS_IDLE;
            end
            default: state_nxt = CS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= CS_IDLE;
            last_wr <= 1'b0;                         // write wins first tie
        end else begin
            state <= state_nxt;
            if (wr_take) last_wr <= 1'b1;
            else if (rd_take) last_wr <= 1'b0;
        end
    end

    // --------------------
    // winning request
    always_ff @(posedge clk) begin
        if (wr_take) begin
            access.op    <= OP_WRITE;
            access.addr  <= wr_req.addr;
            access.len   <= wr_req.len;
            access.wdata <= wr_req.data;
        end else if (rd_take) begin
            access.op    <= OP_READ;
            access.addr  <= rd_req.addr;
            access.len   <= rd_req.len;
            access.wdata <= '0;                      // no payload on reads
        end
    end

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // --------------------
    // widths
    localparam int ADDR_W      = 32;         // byte address
    localparam int DWORD_BYTES = 4;          // bytes per bus word
    localparam int MAX_LEN     = 4;          // longest access in bytes
    localparam int BURST_W     = 4;          // avm_burstcount width

    typedef logic [ADDR_W-1:0]              addr_t;
    typedef logic [ADDR_W-1:2]              dword_addr_t;   // 30 bits
    typedef logic [8*DWORD_BYTES-1:0]       dword_t;
    typedef logic [DWORD_BYTES-1:0]         byte_en_t;
    typedef logic [$clog2(MAX_LEN+1)-1:0]   len_t;          // 1..4 legal

    // --------------------
    // encodings
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } access_op_t;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_ISSUE,
        CS_WAIT_WR,
        CS_WAIT_RD
    } ctrl_state_t;

    typedef enum logic [1:0] {
        BS_IDLE,
        BS_WRITE,
        BS_READ_REQ,
        BS_READ_DATA
    } bus_state_t;

    // --------------------
    // grouped signals
    typedef struct packed {
        addr_t      addr;
        len_t       len;
    } rd_req_t;

    typedef struct packed {
        addr_t      addr;
        len_t       len;
        dword_t     data;           // bytes right-aligned
    } wr_req_t;

    typedef struct packed {
        access_op_t op;
        addr_t      addr;
        len_t       len;
        dword_t     wdata;
    } access_t;

    typedef struct packed {
        access_op_t                 op;
        dword_addr_t                dword_addr;
        logic                       two_beats;  // access crosses a dword
        byte_en_t                   be0;
        byte_en_t                   be1;
        logic [2*8*DWORD_BYTES-1:0] wdata;      // beat 1 in upper half
        logic [1:0]                 offset;     // byte inside first dword
        len_t                       len;
    } burst_cmd_t;

endpackage

`default_nettype wire
